//--- nes_glue_settings.svh
////////////////////////////////////////////////////////////
// nes glue settings
// bus widths and the mappers that carry expansion audio
////////////////////////////////////////////////////////////
`ifndef NES_GLUE_SETTINGS_SVH
`define NES_GLUE_SETTINGS_SVH

// cartridge side
`define NES_MEM_ADDR_W 22

// softcore side
`define NES_RV_ADDR_W 23   // byte address
`define NES_WORD_W    32

// sdram softcore port
`define NES_HALF_W    16

// mapper numbers with expansion audio
`define NES_MAPPER_VRC6A 8'd24
`define NES_MAPPER_VRC6B 8'd26
`define NES_MAPPER_N163  8'd19

`endif

//--- nes_mem_pkg.sv
////////////////////////////////////////////////////////////
// memory side types
// cartridge port, softcore bus and the bridge FSM states
////////////////////////////////////////////////////////////
`include "nes_glue_settings.svh"

package nes_mem_pkg;

    // cartridge memory port
    typedef logic [`NES_MEM_ADDR_W-1:0] mem_addr_t;
    typedef logic [7:0]                 mem_byte_t;

    // softcore bus
    typedef logic [`NES_RV_ADDR_W-1:0]  rv_addr_t;
    typedef logic [`NES_HALF_W-1:0]     rv_half_t;
    typedef logic [`NES_WORD_W-1:0]     rv_word_t;
    typedef logic [`NES_WORD_W/8-1:0]   rv_strb_t;   // one per byte
    typedef logic [`NES_HALF_W/8-1:0]   half_ds_t;   // byte selects of a half

    // loader flags, mapper number in 7:0
    typedef logic [63:0]                mapper_flags_t;

    ////////////////////////////////////////////////////////////
    // bridge states
    ////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {
        rv_idle,       // waiting for a new request
        rv_wait_lo,    // low half in flight
        rv_data_lo,    // capture low read half
        rv_wait_hi,    // high half in flight
        rv_data_hi     // read word complete
    } rv_state_t;

endpackage

//--- nes_pad_pkg.sv
////////////////////////////////////////////////////////////
// controller side types
// analog pad receive bytes and NES button vectors
////////////////////////////////////////////////////////////

package nes_pad_pkg;

    // one receive byte of the analog pad, active low
    // byte 0 is L D R U START R3 L3 SELECT from bit 7 down
    // byte 1 is SQUARE X O TRIANGLE R1 L1 R2 L2 from bit 7 down
    typedef logic [7:0] pad_byte_t;

    // NES buttons, active high
    // R L D U START SELECT B A from bit 7 down to bit 0
    typedef logic [7:0] nes_buttons_t;

endpackage

//--- rv_mem_bridge.sv
////////////////////////////////////////////////////////////
// softcore memory bridge
// turns 32-bit softcore requests into 16-bit sdram toggle
// requests and reassembles the read word
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "nes_glue_settings.svh"

module rv_mem_bridge (
    input  logic                  clk,
    input  logic                  sys_resetn,
    // softcore
    input  logic                  i_rv_valid,
    input  nes_mem_pkg::rv_addr_t i_rv_addr,
    input  nes_mem_pkg::rv_word_t i_rv_wdata,
    input  nes_mem_pkg::rv_strb_t i_rv_wstrb,
    output logic                  o_rv_ready,
    output nes_mem_pkg::rv_word_t o_rv_rdata,
    // sdram softcore port
    input  logic                  i_sd_req_ack,
    input  nes_mem_pkg::rv_half_t i_sd_dout,
    output logic                  o_sd_req,
    output logic [19:0]           o_sd_addr,
    output nes_mem_pkg::rv_half_t o_sd_din,
    output nes_mem_pkg::half_ds_t o_sd_ds,
    output logic                  o_sd_we
);
    import nes_mem_pkg::*;

    localparam int HW  = `NES_HALF_W;
    localparam int DSW = `NES_HALF_W / 8;

    rv_state_t rv_state;
    logic      rv_valid_r;
    logic      rv_new_req;     // edge seen while busy
    logic      rv_new_req_t;   // edge this cycle
    logic      rv_write;
    logic      rv_word;        // 0 low half, 1 high half
    logic      sd_done;
    half_ds_t  rv_ds;
    half_ds_t  strb_lo;
    half_ds_t  strb_hi;
    rv_half_t  rv_dout0;       // captured low read half

    assign rv_new_req_t = i_rv_valid & ~rv_valid_r;
    assign rv_write     = |i_rv_wstrb;
    assign sd_done      = (o_sd_req == i_sd_req_ack);
    assign strb_lo      = i_rv_wstrb[DSW-1:0];
    assign strb_hi      = i_rv_wstrb[2*DSW-1:DSW];

    // sdram request fields
    assign o_sd_addr  = {i_rv_addr[20:2], rv_word};
    assign o_sd_din   = rv_word ? i_rv_wdata[2*HW-1:HW] : i_rv_wdata[HW-1:0];
    assign o_sd_ds    = rv_ds;
    assign o_sd_we    = rv_write;
    assign o_rv_rdata = {i_sd_dout, rv_dout0};   // high half is live

    ////////////////////////////////////////////////////////////
    // request FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            rv_state   <= rv_idle;
            rv_valid_r <= 1'b0;
            rv_new_req <= 1'b0;
            rv_word    <= 1'b0;
            rv_ds      <= '0;
            o_sd_req   <= 1'b0;
            o_rv_ready <= 1'b0;
        end else begin
            o_rv_ready <= 1'b0;
            rv_valid_r <= i_rv_valid;
            if (rv_new_req_t)
                rv_new_req <= 1'b1;

            case (rv_state)
                rv_idle: begin
                    if (rv_new_req || rv_new_req_t) begin
                        rv_new_req <= 1'b0;
                        o_sd_req   <= ~o_sd_req;
                        if (rv_write && strb_lo == '0) begin
                            // upper half only
                            rv_word  <= 1'b1;
                            rv_ds    <= strb_hi;
                            rv_state <= rv_wait_hi;
                        end else begin
                            rv_word  <= 1'b0;
                            rv_ds    <= rv_write ? strb_lo : '1;
                            rv_state <= rv_wait_lo;
                        end
                    end
                end

                rv_wait_lo: begin
                    if (sd_done) begin
                        if (rv_write && strb_hi == '0) begin
                            // lower half only, done
                            o_rv_ready <= 1'b1;
                            rv_state   <= rv_idle;
                        end else begin
                            o_sd_req <= ~o_sd_req;   // second half
                            rv_word  <= 1'b1;
                            rv_ds    <= rv_write ? strb_hi : '1;
                            rv_state <= rv_write ? rv_wait_hi : rv_data_lo;
                        end
                    end
                end

                rv_data_lo: rv_state <= rv_wait_hi;

                rv_wait_hi: begin
                    if (sd_done) begin
                        if (rv_write) begin
                            o_rv_ready <= 1'b1;
                            rv_state   <= rv_idle;
                        end else begin
                            rv_state <= rv_data_hi;
                        end
                    end
                end

                rv_data_hi: begin
                    o_rv_ready <= 1'b1;
                    rv_state   <= rv_idle;
                end

                default: rv_state <= rv_idle;
            endcase
        end
    end

    // low half is held by the sdram one cycle past its ack
    always_ff @(posedge clk) begin
        if (rv_state == rv_data_lo)
            rv_dout0 <= i_sd_dout;
    end

endmodule

//--- cart_mem_arbiter.sv
////////////////////////////////////////////////////////////
// cartridge memory arbiter
// loader or cpu on the sdram cpu port, mapper flags,
// console reset and sdram phase reference
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "nes_glue_settings.svh"

module cart_mem_arbiter (
    input  logic                       clk,
    input  logic                       sys_resetn,
    // rom loader
    input  logic                       i_loading,
    input  logic                       i_loader_write,
    input  nes_mem_pkg::mem_addr_t     i_loader_addr,
    input  nes_mem_pkg::mem_byte_t     i_loader_data,
    input  logic                       i_loader_done,
    input  nes_mem_pkg::mapper_flags_t i_loader_flags,
    // cpu
    input  nes_mem_pkg::mem_addr_t     i_cpu_addr,
    input  logic                       i_cpu_read,
    input  logic                       i_cpu_write,
    input  nes_mem_pkg::mem_byte_t     i_cpu_dout,
    // sdram cpu port
    output nes_mem_pkg::mem_addr_t     o_mem_addr,
    output nes_mem_pkg::mem_byte_t     o_mem_din,
    output logic                       o_mem_oe,
    output logic                       o_mem_we,
    // console
    output nes_mem_pkg::mapper_flags_t o_mapper_flags,
    output logic                       o_ext_audio,
    output logic                       o_loader_reset,
    output logic                       o_reset_nes,
    output logic                       o_clkref
);
    import nes_mem_pkg::*;

    logic      loading_r;
    logic      loader_write_r;
    logic      loader_we;        // stretched to two cycles
    mem_addr_t loader_addr_mem;
    mem_byte_t loader_data_mem;
    logic [7:0] mapper_num;

    assign o_loader_reset = i_loading & ~loading_r;

    // port select
    assign o_mem_addr = i_loading ? loader_addr_mem : i_cpu_addr;
    assign o_mem_din  = i_loading ? loader_data_mem : i_cpu_dout;
    assign o_mem_oe   = ~i_loading & i_cpu_read;
    assign o_mem_we   = loader_we | i_cpu_write;

    assign mapper_num  = o_mapper_flags[7:0];
    assign o_ext_audio = (mapper_num == `NES_MAPPER_N163) |
                         (mapper_num == `NES_MAPPER_VRC6A) |
                         (mapper_num == `NES_MAPPER_VRC6B);

    ////////////////////////////////////////////////////////////
    // loader writes and flags
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            loading_r      <= 1'b0;
            loader_write_r <= 1'b0;
            loader_we      <= 1'b0;
            o_mapper_flags <= '0;
        end else begin
            loading_r      <= i_loading;
            loader_write_r <= i_loader_write;
            loader_we      <= i_loader_write | loader_write_r;
            if (i_loader_done)
                o_mapper_flags <= i_loader_flags;
        end
    end

    always_ff @(posedge clk) begin
        if (i_loader_write) begin
            loader_addr_mem <= i_loader_addr;
            loader_data_mem <= i_loader_data;
        end
    end

    // console reset follows the download, clkref realigns on release
    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            o_reset_nes <= 1'b1;
            o_clkref    <= 1'b0;
        end else begin
            o_clkref <= ~o_clkref;
            if (~i_loading && loading_r) begin
                o_reset_nes <= 1'b0;
                o_clkref    <= 1'b1;
            end else if (i_loading && ~loading_r) begin
                o_reset_nes <= 1'b1;
            end
        end
    end

endmodule

//--- joypad_port.sv
////////////////////////////////////////////////////////////
// joypad port, one player
// maps pad bytes to NES order and shifts them to the console
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module joypad_port (
    input  logic                      clk,
    input  logic                      sys_resetn,
    input  nes_pad_pkg::pad_byte_t    i_pad_rx0,
    input  nes_pad_pkg::pad_byte_t    i_pad_rx1,
    input  nes_pad_pkg::nes_buttons_t i_gamepad_buttons,
    input  logic                      i_joypad_strobe,
    input  logic                      i_joypad_clock,
    output nes_pad_pkg::nes_buttons_t o_buttons,
    output logic                      o_joypad_data
);
    import nes_pad_pkg::*;

    nes_buttons_t pad_buttons;
    nes_buttons_t joypad_bits;      // serial register, A at bit 0
    logic         joypad_clock_r;
    logic         joypad_clock_fall;

    ////////////////////////////////////////////////////////////
    // button mapping
    ////////////////////////////////////////////////////////////
    assign pad_buttons = ~{i_pad_rx0[5],    // R
                           i_pad_rx0[7],    // L
                           i_pad_rx0[6],    // D
                           i_pad_rx0[4],    // U
                           i_pad_rx0[3],    // START
                           i_pad_rx0[0],    // SELECT
                           i_pad_rx1[6],    // B from X
                           i_pad_rx1[5]};   // A from O

    assign o_buttons = pad_buttons | i_gamepad_buttons;

    ////////////////////////////////////////////////////////////
    // serial out
    ////////////////////////////////////////////////////////////
    assign joypad_clock_fall = ~i_joypad_clock & joypad_clock_r;
    assign o_joypad_data     = joypad_bits[0];

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            joypad_clock_r <= 1'b0;
            joypad_bits    <= '1;
        end else begin
            joypad_clock_r <= i_joypad_clock;
            if (i_joypad_strobe)
                joypad_bits <= o_buttons;   // reload while strobed
            if (joypad_clock_fall)
                joypad_bits <= {1'b1, joypad_bits[7:1]};   // ones after 8 reads
        end
    end

endmodule

//--- nes_glue_top.sv
////////////////////////////////////////////////////////////
// nes glue top level
// softcore bridge, cartridge arbiter and two joypad ports
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module nes_glue_top (
    input  logic                       clk,
    input  logic                       sys_resetn,
    // softcore
    input  logic                       i_rv_valid,
    input  nes_mem_pkg::rv_addr_t      i_rv_addr,
    input  nes_mem_pkg::rv_word_t      i_rv_wdata,
    input  nes_mem_pkg::rv_strb_t      i_rv_wstrb,
    output logic                       o_rv_ready,
    output nes_mem_pkg::rv_word_t      o_rv_rdata,
    // sdram softcore port
    input  logic                       i_sd_req_ack,
    input  nes_mem_pkg::rv_half_t      i_sd_dout,
    output logic                       o_sd_req,
    output logic [19:0]                o_sd_addr,
    output nes_mem_pkg::rv_half_t      o_sd_din,
    output nes_mem_pkg::half_ds_t      o_sd_ds,
    output logic                       o_sd_we,
    // rom loader and cpu
    input  logic                       i_loading,
    input  logic                       i_loader_write,
    input  nes_mem_pkg::mem_addr_t     i_loader_addr,
    input  nes_mem_pkg::mem_byte_t     i_loader_data,
    input  logic                       i_loader_done,
    input  nes_mem_pkg::mapper_flags_t i_loader_flags,
    input  nes_mem_pkg::mem_addr_t     i_cpu_addr,
    input  logic                       i_cpu_read,
    input  logic                       i_cpu_write,
    input  nes_mem_pkg::mem_byte_t     i_cpu_dout,
    output nes_mem_pkg::mem_addr_t     o_mem_addr,
    output nes_mem_pkg::mem_byte_t     o_mem_din,
    output logic                       o_mem_oe,
    output logic                       o_mem_we,
    output nes_mem_pkg::mapper_flags_t o_mapper_flags,
    output logic                       o_ext_audio,
    output logic                       o_loader_reset,
    output logic                       o_reset_nes,
    output logic                       o_clkref,
    // controllers
    input  nes_pad_pkg::pad_byte_t     i_pad_rx0_1,
    input  nes_pad_pkg::pad_byte_t     i_pad_rx1_1,
    input  nes_pad_pkg::nes_buttons_t  i_gamepad_buttons1,
    input  nes_pad_pkg::pad_byte_t     i_pad_rx0_2,
    input  nes_pad_pkg::pad_byte_t     i_pad_rx1_2,
    input  nes_pad_pkg::nes_buttons_t  i_gamepad_buttons2,
    input  logic                       i_joypad_strobe,
    input  logic [1:0]                 i_joypad_clock,
    output nes_pad_pkg::nes_buttons_t  o_buttons1,
    output nes_pad_pkg::nes_buttons_t  o_buttons2,
    output logic [1:0]                 o_joypad_data
);

    rv_mem_bridge u_bridge (
        .clk(clk), .sys_resetn(sys_resetn),
        .i_rv_valid(i_rv_valid), .i_rv_addr(i_rv_addr),
        .i_rv_wdata(i_rv_wdata), .i_rv_wstrb(i_rv_wstrb),
        .o_rv_ready(o_rv_ready), .o_rv_rdata(o_rv_rdata),
        .i_sd_req_ack(i_sd_req_ack), .i_sd_dout(i_sd_dout),
        .o_sd_req(o_sd_req), .o_sd_addr(o_sd_addr), .o_sd_din(o_sd_din),
        .o_sd_ds(o_sd_ds), .o_sd_we(o_sd_we)
    );

    cart_mem_arbiter u_arbiter (
        .clk(clk), .sys_resetn(sys_resetn),
        .i_loading(i_loading), .i_loader_write(i_loader_write),
        .i_loader_addr(i_loader_addr), .i_loader_data(i_loader_data),
        .i_loader_done(i_loader_done), .i_loader_flags(i_loader_flags),
        .i_cpu_addr(i_cpu_addr), .i_cpu_read(i_cpu_read),
        .i_cpu_write(i_cpu_write), .i_cpu_dout(i_cpu_dout),
        .o_mem_addr(o_mem_addr), .o_mem_din(o_mem_din),
        .o_mem_oe(o_mem_oe), .o_mem_we(o_mem_we),
        .o_mapper_flags(o_mapper_flags), .o_ext_audio(o_ext_audio),
        .o_loader_reset(o_loader_reset), .o_reset_nes(o_reset_nes),
        .o_clkref(o_clkref)
    );

    // player 1
    joypad_port u_joypad1 (
        .clk(clk), .sys_resetn(sys_resetn),
        .i_pad_rx0(i_pad_rx0_1), .i_pad_rx1(i_pad_rx1_1),
        .i_gamepad_buttons(i_gamepad_buttons1),
        .i_joypad_strobe(i_joypad_strobe), .i_joypad_clock(i_joypad_clock[0]),
        .o_buttons(o_buttons1), .o_joypad_data(o_joypad_data[0])
    );

    // player 2
    joypad_port u_joypad2 (
        .clk(clk), .sys_resetn(sys_resetn),
        .i_pad_rx0(i_pad_rx0_2), .i_pad_rx1(i_pad_rx1_2),
        .i_gamepad_buttons(i_gamepad_buttons2),
        .i_joypad_strobe(i_joypad_strobe), .i_joypad_clock(i_joypad_clock[1]),
        .o_buttons(o_buttons2), .o_joypad_data(o_joypad_data[1])
    );

endmodule

//--- nes_glue_sva.sv
////////////////////////////////////////////////////////////
// nes glue assertions
// ready pulse, sdram toggle protocol, loader write length
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module nes_glue_sva (
    input logic clk,
    input logic sys_resetn,
    input logic i_rv_ready,
    input logic i_sd_req,
    input logic i_sd_req_ack,
    input logic i_mem_we,
    input logic i_cpu_write
);

    // ready is a single cycle pulse
    ready_pulse: assert property (@(posedge clk) disable iff (!sys_resetn)
        i_rv_ready |=> !i_rv_ready)
        else $error("o_rv_ready stayed high for two cycles");

    req_after_ack: assert property (@(posedge clk) disable iff (!sys_resetn)
        (i_sd_req != $past(i_sd_req)) |-> $past(i_sd_req == i_sd_req_ack))   // toggle only when idle
        else $error("o_sd_req toggled before the previous request was acknowledged");

    // stretched loader write ends after two cycles
    we_length: assert property (@(posedge clk) disable iff (!sys_resetn)
        (i_mem_we && !i_cpu_write) ##1 (i_mem_we && !i_cpu_write)
        |=> (!i_mem_we || i_cpu_write))
        else $error("o_mem_we stretched beyond two cycles without a cpu write");

endmodule

bind rv_mem_bridge nes_glue_sva u_bridge_sva (
    .clk(clk), .sys_resetn(sys_resetn), .i_rv_ready(o_rv_ready),
    .i_sd_req(o_sd_req), .i_sd_req_ack(i_sd_req_ack),
    .i_mem_we(1'b0), .i_cpu_write(1'b0)
);

bind cart_mem_arbiter nes_glue_sva u_arbiter_sva (
    .clk(clk), .sys_resetn(sys_resetn), .i_rv_ready(1'b0),
    .i_sd_req(1'b0), .i_sd_req_ack(1'b0),
    .i_mem_we(o_mem_we), .i_cpu_write(i_cpu_write)
);

//--- tb_nes_glue.sv
////////////////////////////////////////////////////////////
// nes glue testbench
// table driven with sdram and console models
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module tb_nes_glue;
    import nes_mem_pkg::*;
    import nes_pad_pkg::*;

    localparam int K_RD = 0, K_WR = 1, K_LOAD = 2, K_CPU = 3, K_PAD = 4;

    logic clk, sys_resetn;
    logic i_rv_valid, o_rv_ready, i_sd_req_ack, o_sd_req, o_sd_we;
    rv_addr_t i_rv_addr;
    rv_word_t i_rv_wdata, o_rv_rdata;
    rv_strb_t i_rv_wstrb;
    rv_half_t i_sd_dout, o_sd_din;
    logic [19:0] o_sd_addr;
    half_ds_t o_sd_ds;
    logic i_loading, i_loader_write, i_loader_done, i_cpu_read, i_cpu_write;
    mem_addr_t i_loader_addr, i_cpu_addr, o_mem_addr;
    mem_byte_t i_loader_data, i_cpu_dout, o_mem_din;
    mapper_flags_t i_loader_flags, o_mapper_flags;
    logic o_mem_oe, o_mem_we, o_ext_audio, o_loader_reset, o_reset_nes, o_clkref;
    pad_byte_t i_pad_rx0_1, i_pad_rx1_1, i_pad_rx0_2, i_pad_rx1_2;
    nes_buttons_t i_gamepad_buttons1, i_gamepad_buttons2, o_buttons1, o_buttons2;
    logic i_joypad_strobe;
    logic [1:0] i_joypad_clock, o_joypad_data;

    int tbl_kind[$];         // stimulus table with one entry per row
    logic [31:0] tbl_addr[$];
    logic [31:0] tbl_data[$];
    logic [15:0] tbl_aux[$];  // strobes, mapper number or gamepad buttons
    logic [15:0] tbl_exp[$];  // half requests, ext audio or buttons of both players

    logic [19:0] rec_addr[$];   // requests seen by the sdram model
    rv_half_t rec_din[$];
    half_ds_t rec_ds[$];
    logic rec_we[$];
    logic sd_req_seen;
    int sd_delay, seed, errors, checks, cycles, cycle_limit, r;

    nes_glue_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

    // read pattern of one sdram half word
    function automatic rv_half_t half_value(input logic [19:0] a);
        return {a[3:0], a[15:4]} ^ {12'h5a3, a[19:16]};
    endfunction

    ////////////////////////////////////////////////////////////
    // sdram model acks each toggle after 1 to 4 cycles
    ////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (!sys_resetn) begin
            sd_req_seen = 1'b0;
            sd_delay    = 0;
        end else if (o_sd_req != sd_req_seen) begin
            sd_req_seen = o_sd_req;
            rec_addr.push_back(o_sd_addr);
            rec_din.push_back(o_sd_din);
            rec_ds.push_back(o_sd_ds);
            rec_we.push_back(o_sd_we);
            sd_delay = 1 + ({$random(seed)} % 4);
        end else if (sd_delay > 0) begin
            sd_delay = sd_delay - 1;
            if (sd_delay == 0) begin
                i_sd_req_ack = sd_req_seen;
                if (!rec_we[$])
                    i_sd_dout = half_value(rec_addr[$]);   // held until next request
            end
        end
    end

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED t=%0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic add_row(input int kind, input logic [31:0] addr, input logic [31:0] data,
                           input logic [15:0] aux, input logic [15:0] exp);
        tbl_kind.push_back(kind);
        tbl_addr.push_back(addr);
        tbl_data.push_back(data);
        tbl_aux.push_back(aux);
        tbl_exp.push_back(exp);
    endtask

    task automatic run_softcore(input int idx);
        logic [31:0] a;
        logic [31:0] d;
        logic [3:0] s;
        logic [19:0] base;
        rv_word_t rdata;
        int readies;
        int i;
        a = tbl_addr[idx];
        d = tbl_data[idx];
        s = (tbl_kind[idx] == K_RD) ? 4'b0000 : tbl_aux[idx][3:0];
        base = {a[20:2], 1'b0};
        rec_addr.delete();
        rec_din.delete();
        rec_ds.delete();
        rec_we.delete();
        i_rv_addr  = a[22:0];
        i_rv_wdata = d;
        i_rv_wstrb = s;
        i_rv_valid = 1'b1;
        @(negedge clk);
        while (!o_rv_ready)
            @(negedge clk);
        rdata      = o_rv_rdata;
        readies    = 1;
        i_rv_valid = 1'b0;
        repeat (3) begin
            @(negedge clk);
            if (o_rv_ready)
                readies++;
        end
        compare("o_rv_ready pulses", readies, 1);
        compare("half requests", rec_addr.size(), tbl_exp[idx]);
        if (s == 4'b0000) begin
            compare("o_rv_rdata", rdata, {half_value(base | 20'd1), half_value(base)});
            for (i = 0; i < rec_addr.size() && i < 2; i++) begin
                compare("o_sd_addr", rec_addr[i], base | i);
                compare("o_sd_ds", rec_ds[i], 2'b11);
                compare("o_sd_we", rec_we[i], 1'b0);
            end
        end else begin
            i = 0;
            if (s[1:0] != 2'b00 && i < rec_addr.size()) begin   // low half first
                compare("o_sd_addr", rec_addr[i], base);
                compare("o_sd_din", rec_din[i], d[15:0]);
                compare("o_sd_ds", rec_ds[i], s[1:0]);
                compare("o_sd_we", rec_we[i], 1'b1);
                i++;
            end
            if (s[3:2] != 2'b00 && i < rec_addr.size()) begin
                compare("o_sd_addr", rec_addr[i], base | 20'd1);
                compare("o_sd_din", rec_din[i], d[31:16]);
                compare("o_sd_ds", rec_ds[i], s[3:2]);
                compare("o_sd_we", rec_we[i], 1'b1);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // rom download with one loader write and the mapper flags
    ////////////////////////////////////////////////////////////
    task automatic run_load(input int idx);
        mapper_flags_t flags;
        flags = {tbl_data[idx], 24'h000100, tbl_aux[idx][7:0]};
        i_cpu_read = 1'b1;   // must not reach o_mem_oe while loading
        i_loading  = 1'b1;
        #1;
        compare("o_loader_reset", o_loader_reset, 1'b1);   // rise not yet registered
        @(negedge clk);
        compare("o_reset_nes", o_reset_nes, 1'b1);
        compare("o_loader_reset", o_loader_reset, 1'b0);
        i_loader_write = 1'b1;
        i_loader_addr  = tbl_addr[idx][21:0];
        i_loader_data  = tbl_data[idx][7:0];
        @(negedge clk);
        i_loader_write = 1'b0;
        repeat (2) begin
            compare("o_mem_we", o_mem_we, 1'b1);
            compare("o_mem_addr", o_mem_addr, tbl_addr[idx][21:0]);
            compare("o_mem_din", o_mem_din, tbl_data[idx][7:0]);
            compare("o_mem_oe", o_mem_oe, 1'b0);
            @(negedge clk);
        end
        compare("o_mem_we", o_mem_we, 1'b0);
        i_loader_done  = 1'b1;
        i_loader_flags = flags;
        @(negedge clk);
        i_loader_done = 1'b0;
        i_loading     = 1'b0;
        i_cpu_read    = 1'b0;
        compare("o_reset_nes", o_reset_nes, 1'b1);   // falls one clock later
        @(negedge clk);
        compare("o_reset_nes", o_reset_nes, 1'b0);
        compare("o_clkref", o_clkref, 1'b1);
        compare("o_mapper_flags", o_mapper_flags, flags);
        compare("o_ext_audio", o_ext_audio, tbl_exp[idx][0]);
        @(negedge clk);
        compare("o_clkref", o_clkref, 1'b0);
    endtask

    task automatic run_cpu(input int idx);
        i_cpu_addr = tbl_addr[idx][21:0];
        i_cpu_dout = tbl_data[idx][7:0];
        i_cpu_read = 1'b1;
        @(negedge clk);
        compare("o_mem_addr", o_mem_addr, tbl_addr[idx][21:0]);
        compare("o_mem_din", o_mem_din, tbl_data[idx][7:0]);
        compare("o_mem_oe", o_mem_oe, 1'b1);
        compare("o_mem_we", o_mem_we, 1'b0);
        i_cpu_read  = 1'b0;
        i_cpu_write = 1'b1;
        @(negedge clk);
        compare("o_mem_we", o_mem_we, 1'b1);
        compare("o_mem_oe", o_mem_oe, 1'b0);
        i_cpu_write = 1'b0;
    endtask

    task automatic shift_out(input int p, input nes_buttons_t exp);
        int i;
        for (i = 0; i < 10; i++) begin
            compare(p ? "o_joypad_data[1]" : "o_joypad_data[0]", o_joypad_data[p],
                    (i < 8) ? exp[i] : 1'b1);
            i_joypad_clock[p] = 1'b1;
            @(negedge clk);
            i_joypad_clock[p] = 1'b0;
            @(negedge clk);
        end
    endtask

    task automatic run_pad(input int idx);
        nes_buttons_t exp1;
        nes_buttons_t exp2;
        {i_pad_rx0_1, i_pad_rx1_1, i_pad_rx0_2, i_pad_rx1_2} = tbl_data[idx];
        {i_gamepad_buttons1, i_gamepad_buttons2} = tbl_aux[idx];
        {exp1, exp2} = tbl_exp[idx];
        i_joypad_strobe = 1'b1;
        @(negedge clk);
        i_joypad_strobe = 1'b0;
        @(negedge clk);
        compare("o_buttons1", o_buttons1, exp1);
        compare("o_buttons2", o_buttons2, exp2);
        shift_out(0, exp1);
        compare("o_joypad_data[1]", o_joypad_data[1], exp2[0]);   // player 2 untouched
        shift_out(1, exp2);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        seed = 7;
        {errors, checks, cycles, cycle_limit} = '0;
        sys_resetn = 1'b0;
        {i_rv_valid, i_rv_addr, i_rv_wdata, i_rv_wstrb, i_sd_req_ack, i_sd_dout} = '0;
        {i_loading, i_loader_write, i_loader_addr, i_loader_data, i_loader_done} = '0;
        {i_loader_flags, i_cpu_addr, i_cpu_read, i_cpu_write, i_cpu_dout} = '0;
        {i_pad_rx0_1, i_pad_rx1_1, i_pad_rx0_2, i_pad_rx1_2} = '1;
        {i_gamepad_buttons1, i_gamepad_buttons2, i_joypad_strobe, i_joypad_clock} = '0;

        add_row(K_RD,   32'h0012344, 32'h0,         16'h0,    16'd2);
        add_row(K_WR,   32'h0000108, 32'hdeadbeef,  16'hf,    16'd2);
        add_row(K_WR,   32'h00a0010, 32'h12345678,  16'h3,    16'd1);
        add_row(K_WR,   32'h01ffffc, 32'hcafef00d,  16'hc,    16'd1);
        add_row(K_RD,   32'h03ff2a0, 32'h0,         16'h0,    16'd2);
        add_row(K_LOAD, 32'h0001234, 32'h0000005a,  16'd24,   16'd1);
        add_row(K_CPU,  32'h0002000, 32'h00000077,  16'h0,    16'd0);
        add_row(K_LOAD, 32'h03f00ff, 32'h000000c3,  16'd4,    16'd0);
        add_row(K_LOAD, 32'h0100000, 32'h00000011,  16'd19,   16'd1);
        add_row(K_CPU,  32'h03fffff, 32'h000000e1,  16'h0,    16'd0);
        // pad bytes active low, gamepad and expected buttons active high
        add_row(K_PAD,  32'h0,       32'hffffffff,  16'h0000, 16'h0000);
        add_row(K_PAD,  32'h0,       32'h5e9fffbf,  16'h0081, 16'hc783);
        add_row(K_PAD,  32'h0,       32'hf7dfa6ff,  16'h2410, 16'h2d3c);
        cycle_limit = 64 * tbl_kind.size() + 200;

        repeat (3) @(negedge clk);
        sys_resetn = 1'b1;
        @(negedge clk);
        compare("o_reset_nes", o_reset_nes, 1'b1);
        compare("o_rv_ready", o_rv_ready, 1'b0);

        for (r = 0; r < tbl_kind.size(); r++) begin
            case (tbl_kind[r])
                K_RD, K_WR: run_softcore(r);
                K_LOAD:     run_load(r);
                K_CPU:      run_cpu(r);
                default:    run_pad(r);
            endcase
        end

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

//--- list.f
+incdir+.
nes_mem_pkg.sv
nes_pad_pkg.sv
rv_mem_bridge.sv
cart_mem_arbiter.sv
joypad_port.sv
nes_glue_top.sv
nes_glue_sva.sv
tb_nes_glue.sv

//--- Bender.yml
package:
  name: nes_glue

export_include_dirs:
  - .

sources:
  - nes_mem_pkg.sv
  - nes_pad_pkg.sv
  - rv_mem_bridge.sv
  - cart_mem_arbiter.sv
  - joypad_port.sv
  - nes_glue_top.sv
  - target: test
    files:
      - nes_glue_sva.sv
      - tb_nes_glue.sv
